//--- Bender.yml
package:
  name: lsp_pol

sources:
  - lsp_pol_pkg.sv
  - basic_ops.sv
  - mpy_32_16.sv
  - l_shl_unit.sv
  - scratch_mem.sv
  - get_lsp_pol.sv
  - lsp_pol_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lsp_pol.sv

//--- basic_ops.sv
`timescale 1ns/1ps

module basic_ops
	import lsp_pol_pkg::*;
(
	input  word_t L_mult_a,
	input  word_t L_mult_b,
	input  word_t L_msu_a,
	input  word_t L_msu_b,
	input  long_t L_msu_c,
	input  word_t L_mac_a,
	input  word_t L_mac_b,
	input  long_t L_mac_c,
	input  word_t mult_a,
	input  word_t mult_b,
	input  word_t add_a,
	input  word_t add_b,
	input  word_t sub_a,
	input  word_t sub_b,
	input  long_t L_add_a,
	input  long_t L_add_b,
	input  long_t L_sub_a,
	input  long_t L_sub_b,
	output long_t L_mult_out,
	output long_t L_msu_out,
	output long_t L_mac_out,
	output word_t mult_out,
	output word_t add_out,
	output word_t sub_out,
	output long_t L_add_out,
	output long_t L_sub_out,
	output logic L_mult_overflow,
	output logic L_mac_overflow,
	output logic L_msu_overflow,
	output logic add_overflow,
	output logic sub_overflow,
	output logic L_add_overflow,
	output logic L_sub_overflow
);

	function automatic word_t sat16(input logic signed [16:0] v);
		if (v[16] != v[15])
			return v[16] ? 16'sh8000 : 16'sh7fff;
		return v[15:0];
	endfunction

	function automatic long_t sat32(input logic signed [32:0] v);
		if (v[32] != v[31])
			return v[32] ? 32'sh8000_0000 : 32'sh7fff_ffff;
		return v[31:0];
	endfunction

	// Only -1 times -1 leaves the Q31 range
	function automatic logic both_min(input word_t a, input word_t b);
		return (a == 16'sh8000) && (b == 16'sh8000);
	endfunction

	function automatic long_t frac_mult(input word_t a, input word_t b);
		logic signed [31:0] p;
		p = a * b;
		if (p == 32'sh4000_0000)
			return 32'sh7fff_ffff;
		return p <<< 1;
	endfunction

	logic signed [31:0] mult_prod;
	long_t mac_prod;
	long_t msu_prod;
	logic signed [32:0] mac_sum;
	logic signed [32:0] msu_diff;
	logic signed [32:0] l_add_sum;
	logic signed [32:0] l_sub_diff;
	logic signed [16:0] add_sum;
	logic signed [16:0] sub_diff;

	always_comb begin
		L_mult_out = frac_mult(L_mult_a, L_mult_b);
		L_mult_overflow = both_min(L_mult_a, L_mult_b);

		// Accumulate ops saturate twice, product then sum
		mac_prod = frac_mult(L_mac_a, L_mac_b);
		mac_sum = L_mac_c + mac_prod;
		L_mac_out = sat32(mac_sum);
		L_mac_overflow = both_min(L_mac_a, L_mac_b) | (mac_sum[32] != mac_sum[31]);

		msu_prod = frac_mult(L_msu_a, L_msu_b);
		msu_diff = L_msu_c - msu_prod;
		L_msu_out = sat32(msu_diff);
		L_msu_overflow = both_min(L_msu_a, L_msu_b) | (msu_diff[32] != msu_diff[31]);

		// Truncating Q15 product
		mult_prod = mult_a * mult_b;
		mult_out = sat16(mult_prod[31:15]);

		add_sum = add_a + add_b;
		add_out = sat16(add_sum);
		add_overflow = add_sum[16] != add_sum[15];

		sub_diff = sub_a - sub_b;
		sub_out = sat16(sub_diff);
		sub_overflow = sub_diff[16] != sub_diff[15];

		l_add_sum = L_add_a + L_add_b;
		L_add_out = sat32(l_add_sum);
		L_add_overflow = l_add_sum[32] != l_add_sum[31];

		l_sub_diff = L_sub_a - L_sub_b;
		L_sub_out = sat32(l_sub_diff);
		L_sub_overflow = l_sub_diff[32] != l_sub_diff[31];
	end

endmodule

//--- get_lsp_pol.sv
`timescale 1ns/1ps

module get_lsp_pol
	import lsp_pol_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic f_opt,
	input  logic lsp_opt,
	output logic done,
	output word_t L_mult_a,
	output word_t L_mult_b,
	input  long_t L_mult_out,
	output word_t L_msu_a,
	output word_t L_msu_b,
	output long_t L_msu_c,
	input  long_t L_msu_out,
	output word_t L_mac_a,
	output word_t L_mac_b,
	output long_t L_mac_c,
	input  long_t L_mac_out,
	output word_t mult_a,
	output word_t mult_b,
	input  word_t mult_out,
	output word_t add_a,
	output word_t add_b,
	input  word_t add_out,
	output word_t sub_a,
	output word_t sub_b,
	input  word_t sub_out,
	output long_t L_add_a,
	output long_t L_add_b,
	input  long_t L_add_out,
	output long_t L_sub_a,
	output long_t L_sub_b,
	input  long_t L_sub_out,
	output logic shl_start,
	output long_t shl_value,
	output word_t shl_count,
	input  logic shl_done,
	input  long_t shl_result,
	output addr_t read_addr,
	output addr_t write_addr,
	output long_t write_data,
	output logic write_en,
	input  long_t read_data
);

	function automatic addr_t f_addr(input logic sel, input logic [2:0] idx);
		return {LSP_F, sel, idx};
	endfunction

	function automatic addr_t lsp_addr(input logic [3:0] idx);
		return {LSP_TEMP, idx};
	endfunction

	function automatic word_t to_word(input logic [3:0] v);
		return word_t'({12'd0, v});
	endfunction

	lsp_state_t state, next_state;
	logic [3:0] i_cnt, next_i_cnt;
	logic [3:0] j_cnt, next_j_cnt;
	logic [3:0] f_ptr, next_f_ptr;
	logic [3:0] lsp_ptr, next_lsp_ptr;
	logic f_sel, next_f_sel;
	long_t temp1, next_temp1;
	long_t temp2, next_temp2;

	long_t mpy_var1;
	word_t mpy_var2;
	long_t mpy_out;
	word_t mpy_L_mult_a, mpy_L_mult_b;
	word_t mpy_mult_a, mpy_mult_b;
	word_t mpy_L_mac_a, mpy_L_mac_b;
	long_t mpy_L_mac_c;

	////////////////////////////////////////////////////////////
	// Multiply helper

	// Split f[j-1] into hi and 15 bit lo
	assign mpy_var1 = {temp1[31:16], 1'b0, temp1[15:1]};
	assign mpy_var2 = read_data[15:0];

	mpy_32_16 i_mpy_32_16 (
		.var1(mpy_var1),
		.var2(mpy_var2),
		.L_mult_in(L_mult_out),
		.mult_in(mult_out),
		.L_mac_in(L_mac_out),
		.out(mpy_out),
		.L_mult_a(mpy_L_mult_a),
		.L_mult_b(mpy_L_mult_b),
		.mult_a(mpy_mult_a),
		.mult_b(mpy_mult_b),
		.L_mac_a(mpy_L_mac_a),
		.L_mac_b(mpy_L_mac_b),
		.L_mac_c(mpy_L_mac_c)
	);

	always_comb begin
		{L_mult_a, L_mult_b} = '0;
		{mult_a, mult_b} = '0;
		{L_mac_a, L_mac_b, L_mac_c} = '0;
		if (state == f0) begin
			// 1.0 in Q24
			L_mult_a = 16'sd4096;
			L_mult_b = 16'sd2048;
		end else if (state == mpy) begin
			L_mult_a = mpy_L_mult_a;
			L_mult_b = mpy_L_mult_b;
			mult_a = mpy_mult_a;
			mult_b = mpy_mult_b;
			L_mac_a = mpy_L_mac_a;
			L_mac_b = mpy_L_mac_b;
			L_mac_c = mpy_L_mac_c;
		end
	end

	////////////////////////////////////////////////////////////
	// Recursion FSM

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			i_cnt <= '0;
			j_cnt <= '0;
			f_ptr <= '0;
			lsp_ptr <= '0;
			f_sel <= 1'b0;
		end else begin
			state <= next_state;
			i_cnt <= next_i_cnt;
			j_cnt <= next_j_cnt;
			f_ptr <= next_f_ptr;
			lsp_ptr <= next_lsp_ptr;
			f_sel <= next_f_sel;
		end
		temp1 <= next_temp1;
		temp2 <= next_temp2;
	end

	always_comb begin
		next_state = state;
		next_i_cnt = i_cnt;
		next_j_cnt = j_cnt;
		next_f_ptr = f_ptr;
		next_lsp_ptr = lsp_ptr;
		next_f_sel = f_sel;
		next_temp1 = temp1;
		next_temp2 = temp2;
		done = 1'b0;
		{L_msu_a, L_msu_b, L_msu_c} = '0;
		{add_a, add_b, sub_a, sub_b} = '0;
		{L_add_a, L_add_b, L_sub_a, L_sub_b} = '0;
		{shl_start, shl_value, shl_count} = '0;
		{read_addr, write_addr, write_data, write_en} = '0;

		case (state)
			idle: begin
				if (start) begin
					next_f_sel = f_opt;
					next_lsp_ptr = {3'd0, lsp_opt};
					next_i_cnt = 4'd2;
					next_j_cnt = 4'd1;
					next_f_ptr = 4'd2;
					next_state = f0;
				end
			end
			f0: begin
				write_addr = f_addr(f_sel, 3'd0);
				write_data = L_mult_out;
				write_en = 1'b1;
				next_state = f1;
			end
			f1: begin
				// f[1] = -2 lsp in Q24
				read_addr = lsp_addr(lsp_ptr);
				L_msu_a = read_data[15:0];
				L_msu_b = 16'sd512;
				write_addr = f_addr(f_sel, 3'd1);
				write_data = L_msu_out;
				write_en = 1'b1;
				add_a = to_word(lsp_ptr);
				add_b = 16'sd2;
				next_lsp_ptr = add_out[3:0];
				next_state = copy;
			end
			copy: begin
				sub_a = to_word(f_ptr);
				sub_b = 16'sd2;
				read_addr = f_addr(f_sel, sub_out[2:0]);
				write_addr = f_addr(f_sel, f_ptr[2:0]);
				write_data = read_data;
				write_en = 1'b1;
				next_state = inner_test;
			end
			inner_test: begin
				if (j_cnt >= i_cnt) begin
					// Pointer is back at f[1]
					read_addr = f_addr(f_sel, f_ptr[2:0]);
					next_temp1 = read_data;
					next_j_cnt = 4'd1;
					next_state = outer_tail;
				end else begin
					sub_a = to_word(f_ptr);
					sub_b = 16'sd1;
					read_addr = f_addr(f_sel, sub_out[2:0]);
					next_temp1 = read_data;
					next_state = mpy;
				end
			end
			mpy: begin
				read_addr = lsp_addr(lsp_ptr);
				shl_start = 1'b1;
				shl_value = mpy_out;
				shl_count = 16'sd1;
				next_temp1 = mpy_out;
				next_state = shl_wait;
			end
			shl_wait: begin
				shl_value = temp1;
				shl_count = 16'sd1;
				if (shl_done) begin
					read_addr = f_addr(f_sel, f_ptr[2:0]);
					next_temp1 = shl_result;
					next_temp2 = read_data;
					next_state = accum;
				end
			end
			accum: begin
				// f[j] + f[j-2] - t0
				sub_a = to_word(f_ptr);
				sub_b = 16'sd2;
				read_addr = f_addr(f_sel, sub_out[2:0]);
				L_add_a = temp2;
				L_add_b = read_data;
				L_sub_a = L_add_out;
				L_sub_b = temp1;
				write_addr = f_addr(f_sel, f_ptr[2:0]);
				write_data = L_sub_out;
				write_en = 1'b1;
				add_a = to_word(j_cnt);
				add_b = 16'sd1;
				next_j_cnt = add_out[3:0];
				next_state = dec_j;
			end
			dec_j: begin
				sub_a = to_word(f_ptr);
				sub_b = 16'sd1;
				next_f_ptr = sub_out[3:0];
				next_state = inner_test;
			end
			outer_tail: begin
				read_addr = lsp_addr(lsp_ptr);
				L_msu_a = read_data[15:0];
				L_msu_b = 16'sd512;
				L_msu_c = temp1;
				write_addr = f_addr(f_sel, f_ptr[2:0]);
				write_data = L_msu_out;
				write_en = 1'b1;
				add_a = to_word(f_ptr);
				add_b = to_word(i_cnt);
				next_f_ptr = add_out[3:0];
				// Last write of the run goes with done
				if (i_cnt == 4'd5) begin
					done = 1'b1;
					next_state = idle;
				end else begin
					next_state = lsp_step;
				end
			end
			lsp_step: begin
				add_a = to_word(lsp_ptr);
				add_b = 16'sd2;
				next_lsp_ptr = add_out[3:0];
				next_state = next_i;
			end
			next_i: begin
				add_a = to_word(i_cnt);
				add_b = 16'sd1;
				next_i_cnt = add_out[3:0];
				next_state = copy;
			end
			default: begin
				next_state = idle;
			end
		endcase
	end

endmodule

//--- l_shl_unit.sv
`timescale 1ns/1ps

module l_shl_unit
	import lsp_pol_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  long_t value,
	input  word_t count,
	output logic done,
	output long_t result
);

	logic busy;
	word_t remaining;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= (count > 16'sd0);
				done <= (count <= 16'sd0);
			end else if (busy && remaining == 16'sd1) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// One bit per cycle
	always_ff @(posedge clock) begin
		if (start) begin
			result <= value;
			remaining <= count;
		end else if (busy) begin
			remaining <= remaining - 16'sd1;
			// Sign and next bit differ so the shift would overflow
			if (result[31] != result[30])
				result <= result[31] ? 32'sh8000_0000 : 32'sh7fff_ffff;
			else
				result <= result << 1;
		end
	end

endmodule

//--- lsp_pol.f
+incdir+.
lsp_pol_pkg.sv
basic_ops.sv
mpy_32_16.sv
l_shl_unit.sv
scratch_mem.sv
get_lsp_pol.sv
lsp_pol_top.sv
tb_lsp_pol.sv

//--- lsp_pol_pkg.sv
package lsp_pol_pkg;

	////////////////////////////////////////////////////////////
	// Codec word types

	// Q15 sample or small integer operand
	typedef logic signed [15:0] word_t;

	// Q24 coefficient or accumulator
	typedef logic signed [31:0] long_t;

	// Scratch address is region code then index
	typedef logic [6:0] addr_t;

	////////////////////////////////////////////////////////////
	// Scratch memory regions

	localparam logic [2:0] LSP_F    = 3'd2;
	localparam logic [2:0] LSP_TEMP = 3'd3;

	////////////////////////////////////////////////////////////
	// Controller states

	typedef enum logic [3:0] {
		idle,
		f0,
		f1,
		copy,
		inner_test,
		mpy,
		shl_wait,
		accum,
		dec_j,
		outer_tail,
		lsp_step,
		next_i
	} lsp_state_t;

endpackage

//--- lsp_pol_top.sv
`timescale 1ns/1ps

module lsp_pol_top
	import lsp_pol_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic f_opt,
	input  logic lsp_opt,
	input  logic host_write_en,
	input  addr_t host_addr,
	input  long_t host_write_data,
	output logic done,
	output long_t host_read_data
);

	// Operator pool
	word_t L_mult_a, L_mult_b;
	long_t L_mult_out;
	word_t L_msu_a, L_msu_b;
	long_t L_msu_c, L_msu_out;
	word_t L_mac_a, L_mac_b;
	long_t L_mac_c, L_mac_out;
	word_t mult_a, mult_b, mult_out;
	word_t add_a, add_b, add_out;
	word_t sub_a, sub_b, sub_out;
	long_t L_add_a, L_add_b, L_add_out;
	long_t L_sub_a, L_sub_b, L_sub_out;

	// Shifter
	logic shl_start, shl_done;
	long_t shl_value, shl_result;
	word_t shl_count;

	// Scratch memory controller port
	addr_t read_addr, write_addr;
	long_t read_data, write_data;
	logic write_en;

	get_lsp_pol i_get_lsp_pol (.*);

	basic_ops i_basic_ops (
		.*,
		.L_mult_overflow(),
		.L_mac_overflow(),
		.L_msu_overflow(),
		.add_overflow(),
		.sub_overflow(),
		.L_add_overflow(),
		.L_sub_overflow()
	);

	l_shl_unit i_l_shl_unit (
		.clock(clock),
		.reset(reset),
		.start(shl_start),
		.value(shl_value),
		.count(shl_count),
		.done(shl_done),
		.result(shl_result)
	);

	scratch_mem i_scratch_mem (.*);

endmodule

//--- mpy_32_16.sv
`timescale 1ns/1ps

module mpy_32_16
	import lsp_pol_pkg::*;
(
	input  long_t var1,
	input  word_t var2,
	input  long_t L_mult_in,
	input  word_t mult_in,
	input  long_t L_mac_in,
	output long_t out,
	output word_t L_mult_a,
	output word_t L_mult_b,
	output word_t mult_a,
	output word_t mult_b,
	output word_t L_mac_a,
	output word_t L_mac_b,
	output long_t L_mac_c
);

	word_t hi;
	word_t lo;

	// var1 arrives as hi word and 15 bit lo word
	assign hi = var1[31:16];
	assign lo = var1[15:0];

	assign L_mult_a = hi;
	assign L_mult_b = var2;
	assign mult_a = lo;
	assign mult_b = var2;

	// lo product times one adds it back at Q31 scale
	assign L_mac_a = mult_in;
	assign L_mac_b = 16'sd1;
	assign L_mac_c = L_mult_in;
	assign out = L_mac_in;

endmodule

//--- scratch_mem.sv
`timescale 1ns/1ps

module scratch_mem
	import lsp_pol_pkg::*;
(
	input  logic clock,
	input  addr_t read_addr,
	input  addr_t write_addr,
	input  long_t write_data,
	input  logic write_en,
	input  addr_t host_addr,
	input  long_t host_write_data,
	input  logic host_write_en,
	output long_t read_data,
	output long_t host_read_data
);

	long_t mem [128];

	assign read_data = mem[read_addr];
	assign host_read_data = mem[host_addr];

	// Controller write wins
	always_ff @(posedge clock) begin
		if (write_en)
			mem[write_addr] <= write_data;
		else if (host_write_en)
			mem[host_addr] <= host_write_data;
	end

endmodule

//--- lsp_pol_model.svh
`ifndef LSP_POL_MODEL_SVH
`define LSP_POL_MODEL_SVH

function automatic int sat_long(input longint v);
	if (v > 64'sh7fff_ffff)
		return 32'sh7fff_ffff;
	if (v < -64'sh8000_0000)
		return 32'sh8000_0000;
	return int'(v);
endfunction

function automatic int sat_word(input int v);
	if (v > 32767)
		return 32767;
	if (v < -32768)
		return -32768;
	return v;
endfunction

function automatic int l_mult(input int a, input int b);
	int p;
	p = a * b;
	if (p == 32'sh4000_0000)
		return 32'sh7fff_ffff;
	return p * 2;
endfunction

function automatic int mult(input int a, input int b);
	return sat_word((a * b) >>> 15);
endfunction

function automatic int l_add(input int a, input int b);
	return sat_long(longint'(a) + longint'(b));
endfunction

function automatic int l_sub(input int a, input int b);
	return sat_long(longint'(a) - longint'(b));
endfunction

function automatic int l_mac(input int c, input int a, input int b);
	return l_add(c, l_mult(a, b));
endfunction

function automatic int l_msu(input int c, input int a, input int b);
	return l_sub(c, l_mult(a, b));
endfunction

// Double precision value times Q15 word
function automatic int mpy_hi_lo(input int v, input int n);
	int hi;
	int lo;
	hi = v >>> 16;
	lo = (v >>> 1) & 32'h7fff;
	return l_mac(l_mult(hi, n), mult(lo, n), 1);
endfunction

function automatic int l_shl(input int v, input int n);
	int r;
	r = v;
	for (int k = 0; k < n; k++) begin
		if (r > 32'sh3fff_ffff)
			r = 32'sh7fff_ffff;
		else if (r < -32'sh4000_0000)
			r = 32'sh8000_0000;
		else
			r = r * 2;
	end
	return r;
endfunction

// Coefficients f[0..5] in Q24 from the odd or even LSP set
function automatic void lsp_pol_coefs(input int lsp[10], input int opt, output int f[6]);
	int p;
	int t0;
	f[0] = l_mult(4096, 2048);
	f[1] = l_msu(0, lsp[opt], 512);
	p = opt + 2;
	for (int i = 2; i <= 5; i++) begin
		f[i] = f[i - 2];
		for (int j = i; j >= 2; j--) begin
			t0 = l_shl(mpy_hi_lo(f[j - 1], lsp[p]), 1);
			f[j] = l_sub(l_add(f[j], f[j - 2]), t0);
		end
		f[1] = l_msu(f[1], lsp[p], 512);
		p = p + 2;
	end
endfunction

`endif

//--- tb_lsp_pol.sv
`timescale 1ns/1ps

module tb_lsp_pol;
	import lsp_pol_pkg::*;

	`include "lsp_pol_model.svh"

	localparam int RUNS = 20;
	localparam int CYCLES_PER_RUN = 400;
	localparam int CYCLE_LIMIT = RUNS * CYCLES_PER_RUN;

	logic clock;
	logic reset;
	logic start;
	logic f_opt;
	logic lsp_opt;
	logic host_write_en;
	addr_t host_addr;
	long_t host_write_data;
	logic done;
	long_t host_read_data;

	int fixed_lsp[10] = '{30000, 26000, 20000, 12000, 4000,
		-5000, -14000, -21000, -27000, -31000};
	int lsp_set[10];

	// Expected contents of both output regions
	int exp_f[2][6];
	bit region_valid[2] = '{1'b0, 1'b0};

	bit run_active = 1'b0;
	int done_count = 0;
	int runs_started = 0;
	int cycle_count = 0;
	int checks = 0;
	int errors = 0;
	bit saw_l_sub_sat = 1'b0;
	bit saw_shl_sat = 1'b0;

	lsp_pol_top dut (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (!reset && done)
			done_count <= done_count + 1;
		if (dut.i_basic_ops.L_sub_overflow)
			saw_l_sub_sat <= 1'b1;
		if (dut.shl_done &&
				(dut.shl_result == 32'sh7fff_ffff || dut.shl_result == 32'sh8000_0000))
			saw_shl_sat <= 1'b1;
	end

	always @(posedge clock) begin
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT never finished its runs", cycle_count);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Protocol checks

	assert property (@(posedge clock) done |-> run_active)
		else begin
			errors++;
			$display("[FAIL] %0t done raised with no run in progress", $time);
		end

	assert property (@(posedge clock) done |=> !done)
		else begin
			errors++;
			$display("[FAIL] %0t done held longer than one cycle", $time);
		end

	// Shift by one takes load plus one step
	assert property (@(posedge clock) disable iff (reset) dut.shl_start |-> ##2 dut.shl_done)
		else begin
			errors++;
			$display("[FAIL] %0t shifter done did not follow start by two cycles", $time);
		end

	////////////////////////////////////////////////////////////
	// Stimulus tasks

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic load_lsp();
		for (int k = 0; k < 10; k++) begin
			host_write_en = 1'b1;
			host_addr = {LSP_TEMP, k[3:0]};
			host_write_data = lsp_set[k];
			next_cycle();
		end
		host_write_en = 1'b0;
	endtask

	task automatic pulse_start(input logic f, input logic l);
		start = 1'b1;
		f_opt = f;
		lsp_opt = l;
		next_cycle();
		start = 1'b0;
	endtask

	// One done pulse for every run started so far
	task automatic check_done_count();
		checks++;
		assert (done_count == runs_started)
			else begin
				errors++;
				$display("[FAIL] %0t saw %0d done pulses for %0d runs",
					$time, done_count, runs_started);
			end
	endtask

	task automatic begin_run(input logic f, input logic l);
		int coef[6];
		check_done_count();
		lsp_pol_coefs(lsp_set, int'(l), coef);
		for (int k = 0; k < 6; k++)
			exp_f[f][k] = coef[k];
		region_valid[f] = 1'b1;
		runs_started++;
		run_active = 1'b1;
		pulse_start(f, l);
	endtask

	task automatic wait_done();
		while (!done)
			next_cycle();
		next_cycle();
		run_active = 1'b0;
	endtask

	task automatic check_region(input logic f);
		long_t got;
		for (int k = 0; k < 6; k++) begin
			host_addr = {LSP_F, f, k[2:0]};
			#2;
			got = host_read_data;
			checks++;
			assert (got == exp_f[f][k])
				else begin
					errors++;
					$display("[FAIL] %0t f_opt %0d f[%0d] is %0d, expected %0d",
						$time, f, k, got, exp_f[f][k]);
				end
			next_cycle();
		end
	endtask

	task automatic check_regions();
		for (int f = 0; f < 2; f++)
			if (region_valid[f])
				check_region(f[0]);
	endtask

	task automatic run_and_check(input logic f, input logic l);
		begin_run(f, l);
		wait_done();
		check_regions();
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0] r;
		void'($urandom(27556));
		reset = 1'b1;
		start = 1'b0;
		f_opt = 1'b0;
		lsp_opt = 1'b0;
		host_write_en = 1'b0;
		host_addr = '0;
		host_write_data = '0;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;

		// Idle stretch where done has to stay low
		repeat (8) next_cycle();

		lsp_set = fixed_lsp;
		load_lsp();
		run_and_check(1'b0, 1'b0);
		run_and_check(1'b1, 1'b1);
		run_and_check(1'b0, 1'b1);
		run_and_check(1'b1, 1'b0);

		// Near -1 drives the shifter and L_sub into saturation
		for (int k = 0; k < 10; k++)
			lsp_set[k] = (k % 2 == 0) ? -32768 : -32700;
		load_lsp();
		run_and_check(1'b0, 1'b0);
		run_and_check(1'b1, 1'b1);

		// Near +1
		for (int k = 0; k < 10; k++)
			lsp_set[k] = (k % 2 == 0) ? 32767 : 32700;
		load_lsp();
		run_and_check(1'b0, 1'b1);
		run_and_check(1'b1, 1'b0);

		for (int n = 0; n < 6; n++) begin
			for (int k = 0; k < 10; k++) begin
				r = $urandom();
				lsp_set[k] = int'($signed(r[15:0]));
			end
			load_lsp();
			run_and_check(n[0], n[1]);
		end

		// Second start during a run
		begin_run(1'b0, 1'b1);
		repeat (5) next_cycle();
		pulse_start(1'b1, 1'b0);
		wait_done();
		check_regions();

		// Back to back runs with start in the cycle after done
		lsp_set = fixed_lsp;
		load_lsp();
		begin_run(1'b0, 1'b0);
		wait_done();
		begin_run(1'b1, 1'b1);
		check_region(1'b0);
		wait_done();
		begin_run(1'b0, 1'b1);
		check_region(1'b1);
		wait_done();
		check_regions();
		check_done_count();

		checks++;
		assert (saw_l_sub_sat)
			else begin
				errors++;
				$display("The stimulus never drove L_sub into saturation");
			end
		checks++;
		assert (saw_shl_sat)
			else begin
				errors++;
				$display("The stimulus never drove the shifter into saturation");
			end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
